// File: flist.f
rv_isa_pkg.sv
ooo_pkg.sv
instr_buffer.sv
rename_regfile.sv
rob_tag_alloc.sv
dispatch_stage.sv
rename_top.sv
rename_assertions.sv
tb_rename.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_rename
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rename.sv
`timescale 1ns/10ps

module tb_rename;
    import rv_isa_pkg::*;
    import ooo_pkg::*;

    localparam int IBUF_DEPTH = 4;
    localparam int ROB_DEPTH  = 8;
    localparam int RS_CREDITS = 2;
    localparam int TIMEOUT    = 200;

    logic       clk = 1'b0;
    logic       rst;
    logic       flush;
    logic       in_valid;
    dec_instr_t in_instr;
    logic       in_credit;
    logic       out_valid;
    disp_pkt_t  out_pkt;
    logic       out_credit;
    commit_t    commit;

    xlen_t      ref_regs [32];
    rob_tag_t   ref_tags [32];
    rob_tag_t   ref_next;
    rob_tag_t   pend_tag [$];  // allocated tags not yet committed, oldest first.
    reg_idx_t   pend_rd [$];
    dec_instr_t sent_q [$];
    disp_pkt_t  got_q [$];

    int errors = 0;
    int timeouts = 0;
    int seed = 73;
    int pc_next = 32'h1000;
    int in_cred = IBUF_DEPTH;
    int rs_owed = 0;  // credits the reservation stations still owe the DUT.
    bit rs_auto = 1'b1;
    int in_credit_cnt = 0;
    int out_cnt = 0;

    rename_top #(
        .IBUF_DEPTH(IBUF_DEPTH),
        .ROB_DEPTH (ROB_DEPTH),
        .RS_CREDITS(RS_CREDITS)
    ) rename_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_credit (out_credit),
        .commit     (commit)
    );

    bind rename_top rename_assertions #(
        .ROB_DEPTH (ROB_DEPTH),
        .RS_CREDITS(RS_CREDITS)
    ) asrt_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .ovf_err    (ibuf_inst.ovf_err),
        .credits    (disp_inst.credits),
        .out_valid  (out_valid),
        .commit     (commit),
        .oldest_tag (alloc_inst.oldest_tag),
        .in_flight  (alloc_inst.in_flight)
    );

    always #2 clk = ~clk;

    // sender and reservation-station side, both sampled on the falling edge.
    always @(negedge clk) begin
        if (out_valid) begin
            got_q.push_back(out_pkt);
            out_cnt++;
            if (rs_auto) begin
                rs_owed++;
            end
        end
        if (in_credit) begin
            in_cred++;
            in_credit_cnt++;
        end
        out_credit = (rs_owed > 0);
        if (rs_owed > 0) begin
            rs_owed--;
        end
    end

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_operand(input string name, input operand_t exp, input operand_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h/%0d, actual %h/%0d",
                     name, exp.value, exp.tag, act.value, act.tag);
            errors++;
        end
    endtask

    task automatic check_pkt(input string name, input disp_pkt_t exp, input disp_pkt_t act);
        if ({act.op, act.rd, act.dest_tag, act.imm, act.pc} !==
            {exp.op, exp.rd, exp.dest_tag, exp.imm, exp.pc}) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
        check_operand({name, " src1"}, exp.src1, act.src1);
        check_operand({name, " src2"}, exp.src2, act.src2);
    endtask

    // stores and branches carry no destination register.
    function automatic bit has_dest(input op_t op);
        return !(op inside {op_nop, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                            op_sb, op_sh, op_sw});
    endfunction

    function automatic operand_t ref_operand(input reg_idx_t idx);
        operand_t opnd;
        opnd.value = (idx == 5'd0) ? '0 : ref_regs[idx];
        opnd.tag   = (idx == 5'd0) ? '0 : ref_tags[idx];
        return opnd;
    endfunction

    task automatic model_flush();
        for (int i = 0; i < 32; i++) begin
            ref_tags[i] = '0;
        end
        ref_next = rob_tag_t'(1);
        pend_tag.delete();
        pend_rd.delete();
        sent_q.delete();
        in_cred = IBUF_DEPTH;
        rs_owed = 0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // drive tasks start and end on a falling edge.
    task automatic send(input op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                        input reg_idx_t rs2);
        dec_instr_t instr;
        int         wait_cnt;
        instr.op  = op;
        instr.rd  = rd;
        instr.rs1 = rs1;
        instr.rs2 = rs2;
        instr.imm = $random(seed);
        instr.pc  = pc_next;
        pc_next   = pc_next + 4;
        wait_cnt  = 0;
        while (in_cred == 0 && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (in_cred == 0) begin
            $display("sender got no input credit back within %0d cycles", TIMEOUT);
            timeouts++;
        end else begin
            in_cred--;
            in_valid = 1'b1;
            in_instr = instr;
            sent_q.push_back(instr);
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic expect_pkt(input string name);
        disp_pkt_t  exp;
        dec_instr_t instr;
        int         wait_cnt;
        wait_cnt = 0;
        while (got_q.size() == 0 && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (got_q.size() == 0 || sent_q.size() == 0) begin
            $display("%s: no dispatch packet arrived within %0d cycles", name, TIMEOUT);
            timeouts++;
        end else begin
            instr        = sent_q.pop_front();
            exp.op       = instr.op;
            exp.rd       = instr.rd;
            exp.dest_tag = ref_next;
            exp.src1     = ref_operand(instr.rs1);
            exp.src2     = ref_operand(instr.rs2);
            exp.imm      = instr.imm;
            exp.pc       = instr.pc;
            check_pkt(name, exp, got_q.pop_front());
            pend_tag.push_back(ref_next);
            pend_rd.push_back(has_dest(instr.op) ? instr.rd : 5'd0);
            if (has_dest(instr.op) && instr.rd != 5'd0) begin
                ref_tags[instr.rd] = ref_next;
            end
            ref_next = (ref_next == rob_tag_t'(ROB_DEPTH)) ? rob_tag_t'(1)
                                                            : ref_next + rob_tag_t'(1);
        end
    endtask

    task automatic commit_oldest(input xlen_t data, input bit with_flush);
        if (pend_tag.size() == 0) begin
            $display("commit requested while no tag was in flight");
            errors++;
        end else begin
            commit.valid = 1'b1;
            commit.tag   = pend_tag.pop_front();
            commit.rd    = pend_rd.pop_front();
            commit.data  = data;
            flush        = with_flush;
            if (commit.rd != 5'd0) begin
                ref_regs[commit.rd] = data;
                if (ref_tags[commit.rd] == commit.tag) begin
                    ref_tags[commit.rd] = '0;
                end
            end
            if (with_flush) begin
                model_flush();
            end
            @(negedge clk);
            commit = '0;
            flush  = 1'b0;
        end
    endtask

    task automatic flush_pipe();
        flush = 1'b1;
        model_flush();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic test_reset_reads();
        check_count("out_valid after reset", 0, int'(out_valid));
        check_count("in_credit after reset", 0, int'(in_credit));
        send(op_add, 5'd10, 5'd3, 5'd31);
        send(op_addi, 5'd11, 5'd20, 5'd0);
        send(op_sub, 5'd12, 5'd7, 5'd8);
        repeat (3) expect_pkt("reset_reads");
        flush_pipe();
    endtask

    task automatic test_renaming();
        send(op_add, 5'd5, 5'd1, 5'd2);
        send(op_add, 5'd7, 5'd5, 5'd0);
        send(op_sw, 5'd7, 5'd5, 5'd7);   // takes a tag, x7 keeps its writer.
        send(op_add, 5'd8, 5'd7, 5'd0);
        send(op_beq, 5'd5, 5'd5, 5'd8);
        send(op_add, 5'd5, 5'd5, 5'd5);  // reads the older tag of its own rd.
        send(op_add, 5'd9, 5'd5, 5'd0);
        repeat (7) expect_pkt("renaming");
        flush_pipe();
    endtask

    task automatic test_commit();
        send(op_add, 5'd5, 5'd0, 5'd0);
        expect_pkt("commit first writer");
        commit_oldest(32'h0000_5a05, 1'b0);
        send(op_add, 5'd6, 5'd5, 5'd0);
        expect_pkt("commit reader");
        send(op_add, 5'd6, 5'd0, 5'd0);
        expect_pkt("commit second writer");
        commit_oldest(32'h0000_6a06, 1'b0);
        send(op_add, 5'd10, 5'd6, 5'd5);
        expect_pkt("commit renamed again");
        send(op_add, 5'd11, 5'd6, 5'd6);
        commit_oldest(32'h0000_6b06, 1'b0);  // lands in the dispatch cycle.
        expect_pkt("commit bypass");
        send(op_add, 5'd12, 5'd6, 5'd0);
        expect_pkt("commit after bypass");
        flush_pipe();
    endtask

    task automatic test_back_pressure();
        rs_auto       = 1'b0;
        out_cnt       = 0;
        in_credit_cnt = 0;
        for (int i = 0; i < IBUF_DEPTH; i++) begin
            send(op_add, 5'(13 + i), 5'd0, 5'd1);
        end
        idle(20);
        check_count("back_pressure held", RS_CREDITS, got_q.size());
        repeat (RS_CREDITS) expect_pkt("back_pressure");
        for (int i = RS_CREDITS; i < IBUF_DEPTH; i++) begin
            rs_owed++;
            expect_pkt("back_pressure release");
            idle(5);
            check_count("one packet per credit", 0, got_q.size());
        end
        check_count("dispatched packets", IBUF_DEPTH, out_cnt);
        check_count("in_credit pulses", IBUF_DEPTH, in_credit_cnt);
        flush_pipe();
        rs_auto = 1'b1;
    endtask

    task automatic test_rob_full();
        for (int i = 0; i < ROB_DEPTH + 2; i++) begin
            send(op_addi, 5'(20 + i % 4), 5'd0, 5'd0);
        end
        repeat (ROB_DEPTH) expect_pkt("rob_full fill");
        idle(20);
        check_count("rob_full held", 0, got_q.size());
        commit_oldest(32'h0000_f001, 1'b0);
        expect_pkt("rob_full release 1");
        idle(5);
        check_count("rob_full one per commit", 0, got_q.size());
        commit_oldest(32'h0000_f002, 1'b0);
        expect_pkt("rob_full release 2");
        flush_pipe();
    endtask

    task automatic test_flush();
        send(op_add, 5'd14, 5'd0, 5'd0);
        send(op_add, 5'd15, 5'd0, 5'd0);
        repeat (2) expect_pkt("flush setup");
        commit_oldest(32'h0000_e014, 1'b0);
        idle(5);
        rs_auto = 1'b0;
        send(op_add, 5'd16, 5'd14, 5'd0);
        send(op_add, 5'd17, 5'd15, 5'd0);
        repeat (2) expect_pkt("flush credits used");
        send(op_add, 5'd18, 5'd0, 5'd0);
        send(op_add, 5'd19, 5'd0, 5'd0);
        idle(20);
        check_count("flush stuck", 0, got_q.size());
        commit_oldest(32'h0000_e015, 1'b1);
        rs_auto = 1'b1;
        idle(20);
        check_count("flushed packets", 0, got_q.size());
        send(op_add, 5'd20, 5'd14, 5'd15);
        send(op_add, 5'd21, 5'd16, 5'd17);
        repeat (2) expect_pkt("after flush");
    endtask

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_credit = 1'b0;
        commit     = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        model_flush();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset_reads();
        test_renaming();
        test_commit();
        test_back_pressure();
        test_rob_full();
        test_flush();
        idle(5);
        $display("tb_rename done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: rename_assertions.sv
`timescale 1ns/10ps

module rename_assertions #(
    parameter int ROB_DEPTH  = 8,
    parameter int RS_CREDITS = 2
) (
    input logic                              clk,
    input logic                              rst,
    input logic                              flush,
    input logic                              ovf_err,
    input logic [$clog2(RS_CREDITS + 1)-1:0] credits,
    input logic                              out_valid,
    input ooo_pkg::commit_t                  commit,
    input ooo_pkg::rob_tag_t                 oldest_tag,
    input logic [$clog2(ROB_DEPTH + 1)-1:0]  in_flight
);
    localparam int CRD_W = $clog2(RS_CREDITS + 1);

    int pkts_open;  // packets seen on out_valid, less the commits since.

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pkts_open <= 0;
        end else begin
            pkts_open <= pkts_open + int'(out_valid) - int'(commit.valid);
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (rst) !ovf_err)
        else $error("instruction buffer was pushed while full");

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CRD_W'(RS_CREDITS))
        else $error("output credit count exceeds the reservation-station credits");

    // a packet on out_valid holds one more tag than the ones counted so far.
    no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (pkts_open < ROB_DEPTH))
        else $error("packet dispatched while the reorder buffer was full");

    commit_in_order: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> ((commit.tag == oldest_tag) && (in_flight != '0)))
        else $error("commit tag is not the oldest allocated tag");

endmodule

// File: rename_top.sv
`timescale 1ns/10ps

module rename_top #(
    parameter int IBUF_DEPTH = 4,
    parameter int ROB_DEPTH  = 8,
    parameter int RS_CREDITS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                in_valid,
    input  ooo_pkg::dec_instr_t in_instr,
    output logic                in_credit,
    output logic                out_valid,
    output ooo_pkg::disp_pkt_t  out_pkt,
    input  logic                out_credit,
    input  ooo_pkg::commit_t    commit
);
    import ooo_pkg::*;

    logic       head_valid;
    dec_instr_t head_instr;
    logic       advance;
    logic       rob_full;
    rob_tag_t   alloc_tag;
    operand_t   src1;
    operand_t   src2;

    instr_buffer #(
        .IBUF_DEPTH(IBUF_DEPTH)
    ) ibuf_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .head_valid (head_valid),
        .head_instr (head_instr),
        .advance    (advance)
    );

    // the head is renamed in the same cycle that it is dispatched.
    rename_regfile rf_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .rd_instr   (head_instr),
        .rename_en  (advance),
        .rename_tag (alloc_tag),
        .src1       (src1),
        .src2       (src2),
        .commit     (commit)
    );

    rob_tag_alloc #(
        .ROB_DEPTH(ROB_DEPTH)
    ) alloc_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .alloc     (advance),
        .alloc_tag (alloc_tag),
        .full      (rob_full),
        .commit    (commit)
    );

    dispatch_stage #(
        .RS_CREDITS(RS_CREDITS)
    ) disp_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .head_valid (head_valid),
        .head_instr (head_instr),
        .rob_full   (rob_full),
        .dest_tag   (alloc_tag),
        .src1       (src1),
        .src2       (src2),
        .advance    (advance),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_credit (out_credit)
    );

endmodule

// File: dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage #(
    parameter int RS_CREDITS = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                head_valid,
    input  ooo_pkg::dec_instr_t head_instr,
    input  logic                rob_full,
    input  ooo_pkg::rob_tag_t   dest_tag,
    input  ooo_pkg::operand_t   src1,
    input  ooo_pkg::operand_t   src2,
    output logic                advance,
    output logic                out_valid,
    output ooo_pkg::disp_pkt_t  out_pkt,
    input  logic                out_credit
);
    import ooo_pkg::*;

    localparam int CRD_W = $clog2(RS_CREDITS + 1);

    logic [CRD_W-1:0] credits;
    logic             credit_ok;
    disp_pkt_t        pkt_next;

    // a credit coming back this cycle can be spent right away.
    assign credit_ok = (credits != '0) || out_credit;
    assign advance   = head_valid && !rob_full && credit_ok;

    always_comb begin
        pkt_next.op       = head_instr.op;
        pkt_next.rd       = head_instr.rd;
        pkt_next.dest_tag = dest_tag;
        pkt_next.src1     = src1;
        pkt_next.src2     = src2;
        pkt_next.imm      = head_instr.imm;
        pkt_next.pc       = head_instr.pc;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credits   <= CRD_W'(RS_CREDITS);
            out_valid <= 1'b0;  // a packet formed in the flush cycle is dropped.
        end else begin
            credits   <= credits - CRD_W'(advance) + CRD_W'(out_credit);
            out_valid <= advance;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_pkt <= pkt_next;
        end
    end

endmodule

// File: rob_tag_alloc.sv
`timescale 1ns/10ps

module rob_tag_alloc #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              alloc,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              full,
    input  ooo_pkg::commit_t  commit
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    rob_tag_t         next_tag;
    rob_tag_t         oldest_tag;  // tag the next commit is expected to carry.
    logic [CNT_W-1:0] in_flight;
    logic             retire;

    function automatic rob_tag_t tag_inc(input rob_tag_t tag);
        if (tag == rob_tag_t'(ROB_DEPTH)) begin
            return rob_tag_t'(1);  // tag zero is never handed out.
        end
        return tag + rob_tag_t'(1);
    endfunction

    assign alloc_tag = next_tag;
    assign full      = (in_flight == CNT_W'(ROB_DEPTH));
    assign retire    = commit.valid && (commit.tag == oldest_tag) && (in_flight != '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            next_tag   <= rob_tag_t'(1);
            oldest_tag <= rob_tag_t'(1);
            in_flight  <= '0;
        end else begin
            if (alloc) begin
                next_tag <= tag_inc(next_tag);
            end
            if (retire) begin
                oldest_tag <= tag_inc(oldest_tag);
            end
            in_flight <= in_flight + CNT_W'(alloc) - CNT_W'(retire);
        end
    end

endmodule

// File: rename_regfile.sv
`timescale 1ns/10ps

module rename_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  ooo_pkg::dec_instr_t rd_instr,
    input  logic                rename_en,
    input  ooo_pkg::rob_tag_t   rename_tag,
    output ooo_pkg::operand_t   src1,
    output ooo_pkg::operand_t   src2,
    input  ooo_pkg::commit_t    commit
);
    import rv_isa_pkg::*;
    import ooo_pkg::*;

    localparam int NUM_REGS = 32;

    xlen_t    regs [NUM_REGS];
    rob_tag_t tags [NUM_REGS];
    logic     do_rename;

    // a commit landing in this cycle is forwarded so the operand is already final.
    function automatic operand_t read_src(input reg_idx_t idx);
        operand_t opnd;
        opnd.value = regs[idx];
        opnd.tag   = tags[idx];
        if (idx == '0) begin
            opnd = '0;
        end else if (commit.valid && (opnd.tag != '0) && (commit.tag == opnd.tag)) begin
            opnd.value = commit.data;
            opnd.tag   = '0;
        end
        return opnd;
    endfunction

    // operands see the tag from before this instruction's own rename.
    always_comb begin
        src1 = read_src(rd_instr.rs1);
        src2 = read_src(rd_instr.rs2);
    end

    assign do_rename = rename_en && writes_rd(rd_instr.op) && (rd_instr.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit.valid && (commit.rd != '0)) begin
                regs[commit.rd] <= commit.data;  // data is written even during a flush.
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end

            // a new rename of the same rd overrides the tag clear above.
            if (flush) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                    tags[i] <= '0;
                end
            end else if (do_rename) begin
                tags[rd_instr.rd] <= rename_tag;
            end
        end
    end

endmodule

// File: instr_buffer.sv
`timescale 1ns/10ps

module instr_buffer #(
    parameter int IBUF_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                in_valid,
    input  ooo_pkg::dec_instr_t in_instr,
    output logic                in_credit,
    output logic                head_valid,
    output ooo_pkg::dec_instr_t head_instr,
    input  logic                advance
);
    import ooo_pkg::*;

    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    dec_instr_t       mem [IBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;
    logic             ovf_err;  // sticky, set when the sender pushes into a full buffer.

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IBUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign full       = (count == CNT_W'(IBUF_DEPTH));
    assign head_valid = (count != '0);
    assign head_instr = mem[rd_ptr];
    assign push       = in_valid && !full;
    assign pop        = advance && head_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
            ovf_err   <= 1'b0;
        end else if (flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;  // the sender refills its own credits on flush.
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count     <= count + CNT_W'(push) - CNT_W'(pop);
            in_credit <= pop;  // one credit back per released entry.
            if (in_valid && full) begin
                ovf_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr;
        end
    end

endmodule

// File: ooo_pkg.sv
package ooo_pkg;

    localparam int TAG_W = 4;

    // tag zero means the register has no pending writer.
    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        rv_isa_pkg::op_t      op;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::xlen_t    imm;
        rv_isa_pkg::xlen_t    pc;
    } dec_instr_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t value;  // only final when tag is zero.
        rob_tag_t          tag;
    } operand_t;

    typedef struct packed {
        rv_isa_pkg::op_t      op;
        rv_isa_pkg::reg_idx_t rd;
        rob_tag_t             dest_tag;
        operand_t             src1;
        operand_t             src2;
        rv_isa_pkg::xlen_t    imm;
        rv_isa_pkg::xlen_t    pc;
    } disp_pkt_t;

    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::reg_idx_t rd;
        rob_tag_t             tag;
        rv_isa_pkg::xlen_t    data;
    } commit_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;  // x0 is hardwired to zero.

    // grouped so that the ops without a destination sit together.
    typedef enum logic [5:0] {
        op_nop,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_sb, op_sh, op_sw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and
    } op_t;

    function automatic logic writes_rd(input op_t op);
        logic wr;
        case (op)
            op_nop,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_sb, op_sh, op_sw: begin
                wr = 1'b0;  // stores and branches leave rd alone.
            end
            default: begin
                wr = 1'b1;
            end
        endcase
        return wr;
    endfunction

endpackage
